// ==== conv_pkg.sv ====
// ===================================================================
// charger control package
// shared widths, gate and sequencer types, dead-time table
// and the fixed constants of the battery-current loop
// ===================================================================
`default_nettype none

package conv_pkg;

   // ===================================================================
   // widths and types
   // ===================================================================

   // gate order: leg-1 high, leg-2 high, leg-1 low, leg-2 low
   typedef logic [3:0] gate_t;
   // raw rectifier ADC code
   typedef logic [7:0] adc8_t;
   // unsigned current in mA
   typedef logic [31:0] ma_t;
   // signed loop quantity (error, integrator, phi)
   typedef logic signed [31:0] ctrl_t;
   // dead-time select as on the board DIP switches
   typedef logic [1:0] dt_sel_t;

   // start-up sequencer states
   typedef enum logic [1:0] {
      SEQ_OFF,
      SEQ_BOOT,
      SEQ_FORCE,
      SEQ_RUN
   } seq_state_e;

   // ===================================================================
   // dead time
   // ===================================================================

   localparam int DT_CNT_W = 4;
   typedef logic [DT_CNT_W-1:0] dt_cyc_t;

   // select 00 -> 8, 01 -> 4, 10 -> 2, 11 -> 6 clock cycles
   localparam dt_cyc_t DEADTIME_CYC [4] = '{4'd8, 4'd4, 4'd2, 4'd6};

   // ===================================================================
   // current loop
   // ===================================================================

   // moving average window, power of two
   localparam int AVG_DEPTH = 4;
   localparam int AVG_SHIFT = $clog2(AVG_DEPTH);
   // mean is truncated to a 128 mA grid before the error
   localparam int ROUND_SHIFT = 7;
   // reference comes in dA
   localparam ctrl_t IREF_MA_PER_DA = 32'sd100;
   // bias added to the PI output, phi units
   localparam ctrl_t PHI_OFFSET = 32'sd50;

   // true when both switches of one leg are on
   function automatic logic leg_short(gate_t g);
      return (g[0] && g[2]) || (g[1] && g[3]);
   endfunction

endpackage

`default_nettype wire

// ==== gate_sequencer.sv ====
// ===================================================================
// gate start-up sequencer
// charges the bootstraps, forces one diagonal, then passes the
// switching command on, with shoot-through guard and OV trip
// ===================================================================
`default_nettype none

module gate_sequencer #(
   parameter int              BOOT_CYC   = 10,
   parameter int              FORCE_CYC  = 14,
   parameter conv_pkg::adc8_t OV_LIMIT_V = 8'd50
) (
   input  wire logic            i_arst_n,
   input  wire logic            ADA_DCO,
   input  wire logic            i_enable,
   input  wire conv_pkg::gate_t i_gate_cmd,
   input  wire conv_pkg::adc8_t i_vbat,
   input  wire logic            i_vbat_valid,
   output conv_pkg::gate_t      o_gate_req,
   output logic                 o_ov_trip
);

   import conv_pkg::*;

   // counter saturates one past the forced phase
   localparam int              CNT_W   = $clog2(FORCE_CYC + 2);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(FORCE_CYC + 1);

   logic [CNT_W-1:0] cnt_q;
   seq_state_e       state;
   gate_t            pattern;
   logic             ov_hit;

   // ===================================================================
   // start-up counter
   // ===================================================================

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cnt_q <= '0;
      end else if (!i_enable) begin
         cnt_q <= '0;
      end else if (cnt_q != CNT_MAX) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // state decoded from enable and the count
   always_comb begin
      if (!i_enable) begin
         state = SEQ_OFF;
      end else if (cnt_q <= CNT_W'(BOOT_CYC)) begin
         state = SEQ_BOOT;
      end else if (cnt_q <= CNT_W'(FORCE_CYC)) begin
         state = SEQ_FORCE;
      end else begin
         state = SEQ_RUN;
      end
   end

   // ===================================================================
   // gate pattern
   // ===================================================================

   always_comb begin
      case (state)
         // both low sides on to charge the bootstrap caps
         SEQ_BOOT:  pattern = 4'b1100;
         // leg-1 high with leg-2 low
         SEQ_FORCE: pattern = 4'b1001;
         // external command, dropped if it shorts a leg
         SEQ_RUN:   pattern = leg_short(i_gate_cmd) ? '0 : i_gate_cmd;
         default:   pattern = '0;
      endcase
   end

   // over-voltage only counts once the bridge is running
   assign ov_hit = (state == SEQ_RUN) && i_vbat_valid && (i_vbat > OV_LIMIT_V);

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ov_trip  <= 1'b0;
         o_gate_req <= '0;
      end else begin
         // latch released by dropping enable
         if (!i_enable) begin
            o_ov_trip <= 1'b0;
         end else if (ov_hit) begin
            o_ov_trip <= 1'b1;
         end
         // trip blanks the bridge on the same edge it is raised
         o_gate_req <= (o_ov_trip || ov_hit) ? '0 : pattern;
      end
   end

   // request never shorts a leg, whatever the command
   a_req_no_short: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      !leg_short(o_gate_req));

endmodule

`default_nettype wire

// ==== dead_time_bank.sv ====
// ===================================================================
// dead-time insertion
// delays every gate turn-on by the selected dead time,
// turn-off passes after one register stage
// ===================================================================
`default_nettype none

module dead_time_bank (
   input  wire logic              i_arst_n,
   input  wire logic              ADA_DCO,
   input  wire conv_pkg::gate_t   i_gate_req,
   input  wire conv_pkg::dt_sel_t i_dt_sel,
   output conv_pkg::gate_t        o_gate
);

   import conv_pkg::*;

   localparam int N_SW = $bits(gate_t);

   // delay for the current select
   dt_cyc_t dt_cyc;
   // cycles each request has been high, saturating
   dt_cyc_t on_cnt_q [N_SW];

   assign dt_cyc = DEADTIME_CYC[i_dt_sel];

   // ===================================================================
   // per-switch turn-on counters
   // ===================================================================

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < N_SW; i++) begin
            on_cnt_q[i] <= '0;
         end
         o_gate <= '0;
      end else begin
         for (int i = 0; i < N_SW; i++) begin
            // request low restarts the delay
            if (!i_gate_req[i]) begin
               on_cnt_q[i] <= '0;
            end else if (on_cnt_q[i] < dt_cyc) begin
               on_cnt_q[i] <= on_cnt_q[i] + 1'b1;
            end
            // on only after dt_cyc consecutive high cycles
            // a shorter select mid-count takes effect at once
            o_gate[i] <= i_gate_req[i] && (on_cnt_q[i] >= dt_cyc);
         end
      end
   end

   // ===================================================================
   // checks
   // ===================================================================

   // no leg is ever shorted at the bridge
   a_gate_no_short: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      !leg_short(o_gate));

endmodule

`default_nettype wire

// ==== ibat_sense.sv ====
// ===================================================================
// battery-current sensing
// scales the ADC code to mA and averages the last four samples
// ===================================================================
`default_nettype none

module ibat_sense #(
   parameter conv_pkg::ma_t IBAT_MA_PER_LSB = 32'd40
) (
   input  wire logic            i_arst_n,
   input  wire logic            ADA_DCO,
   input  wire conv_pkg::adc8_t i_ibat,
   input  wire logic            i_ibat_valid,
   output logic                 o_ibat_ready,
   output conv_pkg::ma_t        o_mean_ma,
   output logic                 o_mean_valid,
   input  wire logic            i_mean_ready
);

   import conv_pkg::*;

   ma_t  sample_ma;
   // newest sample at index 0
   ma_t  hist_q [AVG_DEPTH];
   // running sum of the window
   ma_t  sum_q;
   logic take;

   // code to mA
   assign sample_ma = ma_t'(i_ibat) * IBAT_MA_PER_LSB;

   // one mean in flight, no new sample until it leaves
   assign o_ibat_ready = !o_mean_valid;
   assign take         = i_ibat_valid && o_ibat_ready;

   // sum only moves on a new sample, so the mean holds by itself
   assign o_mean_ma = sum_q >> AVG_SHIFT;

   // ===================================================================
   // window and handshake
   // ===================================================================

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < AVG_DEPTH; i++) begin
            hist_q[i] <= '0;
         end
         sum_q        <= '0;
         o_mean_valid <= 1'b0;
      end else begin
         if (take) begin
            hist_q[0] <= sample_ma;
            for (int i = 1; i < AVG_DEPTH; i++) begin
               hist_q[i] <= hist_q[i-1];
            end
            // add the new sample, drop the oldest
            sum_q        <= sum_q + sample_ma - hist_q[AVG_DEPTH-1];
            o_mean_valid <= 1'b1;
         end else if (i_mean_ready) begin
            o_mean_valid <= 1'b0;
         end
      end
   end

   // mean held steady while the loop stalls
   a_mean_held: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      (o_mean_valid && !i_mean_ready) |=> (o_mean_valid && $stable(o_mean_ma)));

endmodule

`default_nettype wire

// ==== pi_current_loop.sv ====
// ===================================================================
// battery-current PI loop
// error in mA, PI with conditional integration, offset and
// clamp to the phase-angle range
// ===================================================================
`default_nettype none

module pi_current_loop #(
   parameter conv_pkg::ctrl_t KP       = 32'sd3,
   parameter int              KP_SHIFT = 13,
   parameter conv_pkg::ctrl_t KI       = 32'sd1,
   parameter int              KI_SHIFT = 12,
   parameter conv_pkg::ctrl_t PHI_MAX  = 32'sd70
) (
   input  wire logic            i_arst_n,
   input  wire logic            ADA_DCO,
   input  wire conv_pkg::ma_t   i_mean_ma,
   input  wire logic            i_mean_valid,
   output logic                 o_mean_ready,
   input  wire conv_pkg::adc8_t i_iref_da,
   output conv_pkg::ctrl_t      o_phi,
   output logic                 o_phi_valid,
   input  wire logic            i_phi_ready
);

   import conv_pkg::*;

   ctrl_t mean_rnd;
   ctrl_t iref_ma;
   ctrl_t err_d;
   ctrl_t err_q;
   ctrl_t integ_q;
   ctrl_t integ_nxt;
   ctrl_t raw;
   ctrl_t phi_sat;
   logic  take;
   logic  busy_q;
   // previous raw output was clamped high / low
   logic  sat_hi_q;
   logic  sat_lo_q;
   logic  aw_hold;

   // accept only when idle and no phi is waiting
   assign o_mean_ready = !busy_q && !o_phi_valid;
   assign take         = i_mean_valid && o_mean_ready;

   // ===================================================================
   // step 1, error
   // ===================================================================

   // mean down to the 128 mA grid
   assign mean_rnd = ctrl_t'((i_mean_ma >> ROUND_SHIFT) << ROUND_SHIFT);
   assign iref_ma  = ctrl_t'(i_iref_da) * IREF_MA_PER_DA;
   assign err_d    = mean_rnd - iref_ma;

   always_ff @(posedge ADA_DCO) begin
      if (take) begin
         err_q <= err_d;
      end
   end

   // ===================================================================
   // steps 2 to 4, PI, offset, clamp
   // ===================================================================

   always_comb begin
      // freeze integration while pushing further into the limit
      aw_hold   = (sat_hi_q && (err_q > 0)) || (sat_lo_q && (err_q < 0));
      integ_nxt = aw_hold ? integ_q : integ_q + err_q * KI;
      raw       = ((err_q * KP) >>> KP_SHIFT) + (integ_nxt >>> KI_SHIFT) + PHI_OFFSET;
   end

   always_comb begin
      if (raw > PHI_MAX) begin
         phi_sat = PHI_MAX;
      end else if (raw < 0) begin
         phi_sat = '0;
      end else begin
         phi_sat = raw;
      end
   end

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         busy_q      <= 1'b0;
         integ_q     <= '0;
         sat_hi_q    <= 1'b0;
         sat_lo_q    <= 1'b0;
         o_phi       <= '0;
         o_phi_valid <= 1'b0;
      end else begin
         // second cycle of the update follows every accept
         busy_q <= take;
         if (busy_q) begin
            integ_q     <= integ_nxt;
            sat_hi_q    <= raw > PHI_MAX;
            sat_lo_q    <= raw < 0;
            o_phi       <= phi_sat;
            o_phi_valid <= 1'b1;
         end else if (i_phi_ready) begin
            o_phi_valid <= 1'b0;
         end
      end
   end

   // phase angle always within the bridge range
   a_phi_range: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      (o_phi >= 0) && (o_phi <= PHI_MAX));

   // held phi does not move until taken
   a_phi_held: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      (o_phi_valid && !i_phi_ready) |=> (o_phi_valid && $stable(o_phi)));

endmodule

`default_nettype wire

// ==== converter_top.sv ====
// ===================================================================
// dual-active-bridge charger control core
// gate start-up and dead time, battery-current PI loop to phi
// ===================================================================
`default_nettype none

module converter_top #(
   parameter int              BOOT_CYC        = 10,
   parameter int              FORCE_CYC       = 14,
   parameter conv_pkg::adc8_t OV_LIMIT_V      = 8'd50,
   parameter conv_pkg::ma_t   IBAT_MA_PER_LSB = 32'd40,
   parameter conv_pkg::ctrl_t KP              = 32'sd3,
   parameter int              KP_SHIFT        = 13,
   parameter conv_pkg::ctrl_t KI              = 32'sd1,
   parameter int              KI_SHIFT        = 12,
   parameter conv_pkg::ctrl_t PHI_MAX         = 32'sd70
) (
   input  wire logic              i_arst_n,
   input  wire logic              ADA_DCO,
   // gate path
   input  wire logic              i_enable,
   input  wire conv_pkg::gate_t   i_gate_cmd,
   input  wire conv_pkg::adc8_t   i_vbat,
   input  wire logic              i_vbat_valid,
   input  wire conv_pkg::dt_sel_t i_dt_sel,
   output conv_pkg::gate_t        o_gate,
   output logic                   o_ov_trip,
   // current path
   input  wire conv_pkg::adc8_t   i_ibat,
   input  wire logic              i_ibat_valid,
   output logic                   o_ibat_ready,
   input  wire conv_pkg::adc8_t   i_iref_da,
   output conv_pkg::ctrl_t        o_phi,
   output logic                   o_phi_valid,
   input  wire logic              i_phi_ready
);

   import conv_pkg::*;

   gate_t gate_req;
   ma_t   mean_ma;
   logic  mean_valid;
   logic  mean_ready;

   // ===================================================================
   // gate path
   // ===================================================================

   gate_sequencer #(
      .BOOT_CYC   (BOOT_CYC),
      .FORCE_CYC  (FORCE_CYC),
      .OV_LIMIT_V (OV_LIMIT_V)
   ) u_gate_sequencer (
      .i_arst_n     (i_arst_n),
      .ADA_DCO      (ADA_DCO),
      .i_enable     (i_enable),
      .i_gate_cmd   (i_gate_cmd),
      .i_vbat       (i_vbat),
      .i_vbat_valid (i_vbat_valid),
      .o_gate_req   (gate_req),
      .o_ov_trip    (o_ov_trip)
   );

   dead_time_bank u_dead_time_bank (
      .i_arst_n   (i_arst_n),
      .ADA_DCO    (ADA_DCO),
      .i_gate_req (gate_req),
      .i_dt_sel   (i_dt_sel),
      .o_gate     (o_gate)
   );

   // ===================================================================
   // current path
   // ===================================================================

   ibat_sense #(
      .IBAT_MA_PER_LSB (IBAT_MA_PER_LSB)
   ) u_ibat_sense (
      .i_arst_n     (i_arst_n),
      .ADA_DCO      (ADA_DCO),
      .i_ibat       (i_ibat),
      .i_ibat_valid (i_ibat_valid),
      .o_ibat_ready (o_ibat_ready),
      .o_mean_ma    (mean_ma),
      .o_mean_valid (mean_valid),
      .i_mean_ready (mean_ready)
   );

   pi_current_loop #(
      .KP       (KP),
      .KP_SHIFT (KP_SHIFT),
      .KI       (KI),
      .KI_SHIFT (KI_SHIFT),
      .PHI_MAX  (PHI_MAX)
   ) u_pi_current_loop (
      .i_arst_n     (i_arst_n),
      .ADA_DCO      (ADA_DCO),
      .i_mean_ma    (mean_ma),
      .i_mean_valid (mean_valid),
      .o_mean_ready (mean_ready),
      .i_iref_da    (i_iref_da),
      .o_phi        (o_phi),
      .o_phi_valid  (o_phi_valid),
      .i_phi_ready  (i_phi_ready)
   );

endmodule

`default_nettype wire

// ==== tb_converter_top.sv ====
// ======================================================================
// testbench for the charger control core
// cycle model of the gate path, transaction model of the current loop
// ======================================================================
`default_nettype none

module tb_converter_top;

   timeunit 1ns;
   timeprecision 1ps;

   import conv_pkg::*;

   // loop and sequencer constants
   localparam int BOOT_CYC   = 10;
   localparam int FORCE_CYC  = 14;
   localparam int OV_LIMIT   = 50;
   localparam int MA_PER_LSB = 40;
   localparam int KP         = 3;
   localparam int KP_SHIFT   = 13;
   localparam int KI         = 1;
   localparam int KI_SHIFT   = 12;
   localparam int PHI_MAX    = 70;
   localparam int PHI_OFS    = 50;
   // dead time in cycles per select value
   localparam int DT_TAB [4] = '{8, 4, 2, 6};

   typedef struct {
      logic    en;
      gate_t   cmd;
      dt_sel_t dt;
      adc8_t   vbat;
      adc8_t   code;
      adc8_t   iref;
      logic    send;
      logic    hold;
      int      ncyc;
   } row_t;

   logic    ADA_DCO;
   logic    i_arst_n;
   logic    i_enable;
   gate_t   i_gate_cmd;
   adc8_t   i_vbat;
   logic    i_vbat_valid;
   dt_sel_t i_dt_sel;
   adc8_t   i_ibat;
   logic    i_ibat_valid;
   logic    o_ibat_ready;
   adc8_t   i_iref_da;
   ctrl_t   o_phi;
   logic    o_phi_valid;
   logic    i_phi_ready;
   gate_t   o_gate;
   logic    o_ov_trip;

   row_t rows[$];
   int   exp_q[$];
   int   seed = 32'h29402c1d;
   int   cyc = 0;
   int   cyc_limit = 1000;
   int   start;

   // gate path model state
   int    m_cnt;
   gate_t m_req;
   gate_t m_pat;
   gate_t m_gate;
   logic  m_trip;
   logic  m_hit;
   int    m_run [4];

   // current loop model state
   int   hist [4] = '{0, 0, 0, 0};
   int   integ = 0;
   logic sat_hi = 1'b0;
   logic sat_lo = 1'b0;

   converter_top u_dut (
      .i_arst_n     (i_arst_n),
      .ADA_DCO      (ADA_DCO),
      .i_enable     (i_enable),
      .i_gate_cmd   (i_gate_cmd),
      .i_vbat       (i_vbat),
      .i_vbat_valid (i_vbat_valid),
      .i_dt_sel     (i_dt_sel),
      .o_gate       (o_gate),
      .o_ov_trip    (o_ov_trip),
      .i_ibat       (i_ibat),
      .i_ibat_valid (i_ibat_valid),
      .o_ibat_ready (o_ibat_ready),
      .i_iref_da    (i_iref_da),
      .o_phi        (o_phi),
      .o_phi_valid  (o_phi_valid),
      .i_phi_ready  (i_phi_ready)
   );

   initial begin
      ADA_DCO = 1'b0;
      forever #4 ADA_DCO = ~ADA_DCO;
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // ======================================================================
   // stimulus table
   // ======================================================================

   task automatic add_row(input logic en, input gate_t cmd, input dt_sel_t dt, input adc8_t vbat,
                          input adc8_t code, input adc8_t iref, input logic send,
                          input logic hold, input int ncyc);
      rows.push_back('{en, cmd, dt, vbat, code, iref, send, hold, ncyc});
   endtask

   function automatic adc8_t next_code();
      return adc8_t'($random(seed));
   endfunction

   task automatic build_table();
      // en cmd dt vbat code iref send hold cycles
      add_row(0, 4'b0000, 2'd0, 8'd20, 8'd255, 8'd0, 1, 0, 4);
      // start-up with the longest dead time
      add_row(1, 4'b0011, 2'd0, 8'd20, 8'd255, 8'd0, 1, 0, 40);
      add_row(0, 4'b0011, 2'd0, 8'd20, 8'd255, 8'd0, 1, 0, 4);
      add_row(0, 4'b0011, 2'd2, 8'd20, 8'd255, 8'd0, 1, 0, 4);
      add_row(1, 4'b0110, 2'd2, 8'd20, 8'd255, 8'd0, 1, 0, 30);
      // shoot-through commands on each leg
      add_row(1, 4'b0101, 2'd2, 8'd20, 8'd255, 8'd0, 1, 0, 12);
      add_row(1, 4'b1010, 2'd2, 8'd20, 8'd255, 8'd0, 1, 0, 12);
      add_row(1, 4'b1001, 2'd2, 8'd20, 8'd255, 8'd0, 1, 0, 12);
      // over-voltage trip, latched until enable drops
      add_row(1, 4'b1001, 2'd2, 8'd60, 8'd255, 8'd0, 1, 0, 12);
      add_row(1, 4'b0110, 2'd2, 8'd20, 8'd255, 8'd0, 1, 0, 12);
      add_row(0, 4'b0110, 2'd2, 8'd20, 8'd255, 8'd0, 1, 0, 4);
      add_row(0, 4'b0110, 2'd1, 8'd20, 8'd255, 8'd0, 1, 0, 4);
      add_row(1, 4'b0011, 2'd1, 8'd20, 8'd255, 8'd0, 1, 0, 30);
      add_row(0, 4'b0011, 2'd1, 8'd20, 8'd255, 8'd0, 1, 0, 4);
      add_row(0, 4'b0011, 2'd3, 8'd20, 8'd255, 8'd0, 1, 0, 4);
      add_row(1, 4'b1100, 2'd3, 8'd20, 8'd255, 8'd0, 1, 0, 30);
      // error reverses after a long saturated stretch
      repeat (4) add_row(1, 4'b1001, 2'd3, 8'd20, 8'd0, 8'd40, 1, 0, 12);
      repeat (4) add_row(1, 4'b0110, 2'd3, 8'd20, 8'd0, 8'd255, 1, 0, 12);
      repeat (4) add_row(1, 4'b0110, 2'd3, 8'd20, next_code(), 8'd60, 1, 0, 12);
      // phi held back, then released
      add_row(1, 4'b0110, 2'd3, 8'd20, next_code(), 8'd60, 1, 1, 12);
      add_row(1, 4'b0110, 2'd3, 8'd20, next_code(), 8'd60, 1, 1, 12);
      add_row(1, 4'b0110, 2'd3, 8'd20, next_code(), 8'd60, 1, 0, 12);
      add_row(0, 4'b0000, 2'd3, 8'd20, next_code(), 8'd60, 1, 0, 8);
   endtask

   // ======================================================================
   // reference models
   // ======================================================================

   function automatic gate_t phase_pattern(input logic en, input int cnt, input gate_t cmd);
      if (!en) return 4'b0000;
      if (cnt <= BOOT_CYC) return 4'b1100;
      if (cnt <= FORCE_CYC) return 4'b1001;
      // a command shorting a leg blanks the bridge
      if ((cmd[0] && cmd[2]) || (cmd[1] && cmd[3])) return 4'b0000;
      return cmd;
   endfunction

   always @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         m_cnt  = 0;
         m_req  = '0;
         m_gate = '0;
         m_trip = 1'b0;
         for (int i = 0; i < 4; i++) begin
            m_run[i] = 0;
         end
      end else begin
         // turn-on needs the request seen high on dead time + 1 edges
         for (int i = 0; i < 4; i++) begin
            m_run[i]  = m_req[i] ? m_run[i] + 1 : 0;
            m_gate[i] = m_run[i] > DT_TAB[i_dt_sel];
         end
         m_pat  = phase_pattern(i_enable, m_cnt, i_gate_cmd);
         m_hit  = i_enable && (m_cnt > FORCE_CYC) && i_vbat_valid && (i_vbat > OV_LIMIT);
         m_req  = (m_trip || m_hit) ? 4'b0000 : m_pat;
         m_trip = i_enable && (m_trip || m_hit);
         m_cnt  = !i_enable ? 0 : ((m_cnt > FORCE_CYC) ? m_cnt : m_cnt + 1);
      end
   end

   task automatic predict_phi(input adc8_t code, input adc8_t iref);
      int ci;
      int ri;
      int mean;
      int err;
      int acc;
      int raw;
      ci = code;
      ri = iref;
      for (int i = 3; i > 0; i--) begin
         hist[i] = hist[i-1];
      end
      hist[0] = ci * MA_PER_LSB;
      mean = (hist[0] + hist[1] + hist[2] + hist[3]) / 4;
      // mean on the 128 mA grid minus the reference in mA
      err = (mean / 128) * 128 - ri * 100;
      if ((sat_hi && err > 0) || (sat_lo && err < 0)) begin
         acc = integ;
      end else begin
         acc = integ + err * KI;
      end
      raw    = ((err * KP) >>> KP_SHIFT) + (acc >>> KI_SHIFT) + PHI_OFS;
      integ  = acc;
      sat_hi = raw > PHI_MAX;
      sat_lo = raw < 0;
      exp_q.push_back((raw > PHI_MAX) ? PHI_MAX : ((raw < 0) ? 0 : raw));
   endtask

   // ======================================================================
   // checks and handshakes
   // ======================================================================

   always @(negedge ADA_DCO) begin
      if (i_arst_n) begin
         assert (!((o_gate[0] && o_gate[2]) || (o_gate[1] && o_gate[3])))
            else stop_run("both switches of one bridge leg were on together");
         assert (o_gate === m_gate)
            else stop_run($sformatf("Fail o_gate got %h expected %h", o_gate, m_gate));
         assert (o_ov_trip === m_trip)
            else stop_run($sformatf("Fail o_ov_trip got %h expected %h", o_ov_trip, m_trip));
      end
   end

   always @(posedge ADA_DCO) begin
      cyc = cyc + 1;
      if (cyc > cyc_limit) begin
         stop_run("timeout, the run did not finish within the cycle limit");
      end
   end

   task automatic send_sample(input adc8_t code);
      i_ibat       = code;
      i_ibat_valid = 1'b1;
      while (!o_ibat_ready) @(negedge ADA_DCO);
      // transfer on the rising edge before the next falling one
      @(negedge ADA_DCO);
      i_ibat_valid = 1'b0;
   endtask

   task automatic collect_phi();
      int exp_phi;
      while (!o_phi_valid) @(negedge ADA_DCO);
      exp_phi = exp_q.pop_front();
      assert (o_phi == exp_phi)
         else stop_run($sformatf("Fail o_phi got %h expected %h", o_phi, exp_phi));
      i_phi_ready = 1'b1;
      @(negedge ADA_DCO);
      i_phi_ready = 1'b0;
   endtask

   task automatic check_held();
      ctrl_t held;
      while (!o_phi_valid) @(negedge ADA_DCO);
      held = o_phi;
      repeat (8) begin
         assert (o_ibat_ready == 1'b0)
            else stop_run($sformatf("Fail o_ibat_ready got %h expected %h", o_ibat_ready, 1'b0));
         assert (o_phi_valid && (o_phi == held))
            else stop_run($sformatf("Fail o_phi got %h expected %h", o_phi, held));
         @(negedge ADA_DCO);
      end
   endtask

   // ======================================================================
   // main sequence
   // ======================================================================

   initial begin
      i_arst_n     = 1'b0;
      i_enable     = 1'b0;
      i_gate_cmd   = '0;
      i_vbat       = '0;
      i_vbat_valid = 1'b0;
      i_dt_sel     = '0;
      i_ibat       = '0;
      i_ibat_valid = 1'b0;
      i_iref_da    = '0;
      i_phi_ready  = 1'b0;
      build_table();
      cyc_limit = rows.size() * 64 + 200;
      repeat (16) @(posedge ADA_DCO);
      @(negedge ADA_DCO);
      // outputs at their reset values
      assert (o_gate == '0)
         else stop_run($sformatf("Fail o_gate got %h expected %h", o_gate, 4'h0));
      assert (o_ov_trip == 1'b0)
         else stop_run($sformatf("Fail o_ov_trip got %h expected %h", o_ov_trip, 1'b0));
      assert (o_phi_valid == 1'b0)
         else stop_run($sformatf("Fail o_phi_valid got %h expected %h", o_phi_valid, 1'b0));
      assert (o_ibat_ready == 1'b1)
         else stop_run($sformatf("Fail o_ibat_ready got %h expected %h", o_ibat_ready, 1'b1));
      assert (o_phi == 0)
         else stop_run($sformatf("Fail o_phi got %h expected %h", o_phi, 32'h0));
      i_arst_n = 1'b1;
      foreach (rows[r]) begin
         i_enable     = rows[r].en;
         i_gate_cmd   = rows[r].cmd;
         i_dt_sel     = rows[r].dt;
         i_vbat       = rows[r].vbat;
         i_vbat_valid = 1'b1;
         i_iref_da    = rows[r].iref;
         start        = cyc;
         if (!rows[r].hold) begin
            while (exp_q.size() > 0) collect_phi();
         end
         if (rows[r].send) begin
            predict_phi(rows[r].code, rows[r].iref);
            send_sample(rows[r].code);
         end
         if (rows[r].hold) begin
            if (exp_q.size() >= 2) check_held();
         end else begin
            while (exp_q.size() > 0) collect_phi();
         end
         while (cyc < start + rows[r].ncyc) @(negedge ADA_DCO);
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// ==== converter_top.f ====
conv_pkg.sv
gate_sequencer.sv
dead_time_bank.sv
ibat_sense.sv
pi_current_loop.sv
converter_top.sv
tb_converter_top.sv
